//--- verilog/rcc_macros.svh
`ifndef RCC_MACROS_SVH
`define RCC_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// bus clock-enable widths
////////////////////////////////////////////////////////////////////////////

// prescaler counter, enough for divide by 512
`define RCC_CNT_W 9

// hpre code width, 16 codes
`define RCC_HPRE_W 4

// apb prescaler code width
// d1ppre, d2ppre1, d2ppre2 and d3ppre share it
`define RCC_PPRE_W 3

`endif

//--- verilog/rcc_pkg.sv
`include "rcc_macros.svh"

package rcc_pkg;

  // hpre: 0..7 pass, 8..11 div 2..16, 12..15 div 64..512
  typedef logic [`RCC_HPRE_W-1:0] t_hpre_code;

  // apb: 0..3 pass, 4..7 div 2..16
  typedef logic [`RCC_PPRE_W-1:0] t_ppre_code;

  typedef struct packed {
    t_hpre_code hpre;
    t_ppre_code d1ppre;
    t_ppre_code d2ppre1;
    t_ppre_code d2ppre2;
    t_ppre_code d3ppre;
  } t_prescale_cfg;

  typedef struct packed {
    logic sleep;
    logic deepsleep;
  } t_core_state;

  // peripheral allocation of one core
  typedef struct packed {
    logic ahb1;
    logic ahb2;
    logic ahb3;
    logic apb1;
    logic apb2;
    logic apb3;
  } t_bus_alloc;

  typedef struct packed {
    logic axi_d1;
    logic ahb3_d1;
    logic apb3_d1;
    logic ahb1_d2;
    logic ahb2_d2;
    logic apb1_d2;
    logic apb2_d2;
    logic flash;
  } t_bridge_busy;

  typedef struct packed {
    logic hclk;
    logic pclk3_d1;
    logic pclk1_d2;
    logic pclk2_d2;
    logic pclk4_d3;
  } t_bus_tick;

  // one bit per bridge, enables and strobes alike
  typedef struct packed {
    logic axi_d1;
    logic ahb3_d1;
    logic apb3_d1;
    logic ahb1_d2;
    logic ahb2_d2;
    logic apb1_d2;
    logic apb2_d2;
    logic ahb4_d3;
    logic apb4_d3;
  } t_bridge_vec;

endpackage

//--- verilog/rcc_prescaler.sv
`timescale 1ns/1ps
`include "rcc_macros.svh"

module rcc_prescaler import rcc_pkg::*; #(
  parameter type SEL_T = t_ppre_code
) (
  input  logic i_sys_clk,
  input  logic i_rst_n,
  input  logic i_advance,
  input  SEL_T i_code,
  output logic o_tick
);

  // a code as wide as hpre gets the hpre decoding
  localparam bit IS_HPRE = ($bits(SEL_T) == `RCC_HPRE_W);

  SEL_T                  code_q;
  logic [`RCC_CNT_W-1:0] cnt_q;
  logic [`RCC_CNT_W-1:0] last;

  // terminal count, divisor minus one
  function automatic logic [`RCC_CNT_W-1:0] last_count(input SEL_T code);
    logic [3:0]            shamt;
    logic [`RCC_CNT_W-1:0] ones;
    shamt = '0;
    ones  = '1;
    if (code[$bits(SEL_T)-1]) begin
      if (IS_HPRE) begin
        // upper half jumps one step, no divide by 32
        shamt = 4'(code[2:0]) + 4'd1 + 4'(code[2]);
      end else begin
        shamt = 4'(code[1:0]) + 4'd1;
      end
    end
    return ~(ones << shamt);
  endfunction

  assign last = last_count(code_q);

  always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      code_q <= '0;
      cnt_q  <= '0;
      o_tick <= 1'b0;
    end else begin
      code_q <= i_code;
      o_tick <= 1'b0;
      if (i_code != code_q) begin
        // new divisor, start counting afresh
        cnt_q <= '0;
      end else if (i_advance) begin
        if (cnt_q == last) begin
          cnt_q  <= '0;
          o_tick <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

endmodule

//--- verilog/rcc_bus_prescalers.sv
`timescale 1ns/1ps

module rcc_bus_prescalers import rcc_pkg::*; (
  input  logic          i_sys_clk,
  input  logic          i_rst_n,
  input  t_prescale_cfg i_cfg,
  output t_bus_tick     o_tick
);

  logic       hclk_tick;
  t_ppre_code ppre_code [4];
  logic [3:0] pclk_tick;

  ////////////////////////////////////////////////////////////////////////////
  // ahb prescaler, runs on every system clock
  ////////////////////////////////////////////////////////////////////////////
  rcc_prescaler #(
    .SEL_T (t_hpre_code)
  ) u_hpre (
    .i_sys_clk (i_sys_clk),
    .i_rst_n   (i_rst_n),
    .i_advance (1'b1),
    .i_code    (i_cfg.hpre),
    .o_tick    (hclk_tick)
  );

  ////////////////////////////////////////////////////////////////////////////
  // apb prescalers, advanced by the hclk tick
  ////////////////////////////////////////////////////////////////////////////
  assign ppre_code[0] = i_cfg.d1ppre;
  assign ppre_code[1] = i_cfg.d2ppre1;
  assign ppre_code[2] = i_cfg.d2ppre2;
  assign ppre_code[3] = i_cfg.d3ppre;

  for (genvar i = 0; i < 4; i++) begin : g_ppre
    rcc_prescaler #(
      .SEL_T (t_ppre_code)
    ) u_ppre (
      .i_sys_clk (i_sys_clk),
      .i_rst_n   (i_rst_n),
      .i_advance (hclk_tick),
      .i_code    (ppre_code[i]),
      .o_tick    (pclk_tick[i])
    );
  end

  assign o_tick.hclk     = hclk_tick;
  assign o_tick.pclk3_d1 = pclk_tick[0];
  assign o_tick.pclk1_d2 = pclk_tick[1];
  assign o_tick.pclk2_d2 = pclk_tick[2];
  assign o_tick.pclk4_d3 = pclk_tick[3];

endmodule

//--- verilog/rcc_gate_ctrl.sv
`timescale 1ns/1ps

module rcc_gate_ctrl import rcc_pkg::*; (
  input  logic         i_sys_clk,
  input  logic         i_rst_n,
  input  t_core_state  i_c1,
  input  t_core_state  i_c2,
  input  t_bus_alloc   i_c1_alloc,
  input  t_bus_alloc   i_c2_alloc,
  input  t_bridge_busy i_busy,
  input  logic         i_d1_run,
  input  logic         i_d2_run,
  input  logic         i_sys_stop,
  output t_bridge_vec  o_bridge_en
);

  logic        c1_sleep_mode;
  logic        c2_sleep_mode;
  t_bus_alloc  alloc_hit;
  logic        d1_ok;
  logic        d2_ok;
  logic        apb1_d2_raw;
  logic        apb2_d2_raw;
  logic        apb3_d1_raw;
  t_bridge_vec en_d;
  t_bridge_vec en_q;

  ////////////////////////////////////////////////////////////////////////////
  // sleep-aware bridge requests
  ////////////////////////////////////////////////////////////////////////////

  // plain sleep, deep-sleep excluded
  assign c1_sleep_mode = i_c1.sleep & ~i_c1.deepsleep;
  assign c2_sleep_mode = i_c2.sleep & ~i_c2.deepsleep;

  // bus kept alive by a sleeping core that owns it
  assign alloc_hit = ({6{c1_sleep_mode}} & i_c1_alloc) |
                     ({6{c2_sleep_mode}} & i_c2_alloc);

  assign apb1_d2_raw = ~i_c2.sleep | alloc_hit.apb1 | i_busy.apb1_d2;
  assign apb2_d2_raw = ~i_c2.sleep | alloc_hit.apb2 | i_busy.apb2_d2;
  assign apb3_d1_raw = ~i_c1.sleep | alloc_hit.apb3 | i_busy.apb3_d1;

  // domain qualification
  assign d1_ok = i_d1_run & ~i_sys_stop;
  assign d2_ok = i_d2_run & ~i_sys_stop;

  always_comb begin
    en_d.axi_d1  = d1_ok & (~i_c1.sleep | i_busy.axi_d1);
    // apb3 hangs off ahb3, flash too
    en_d.ahb3_d1 = d1_ok & (~i_c1.sleep | alloc_hit.ahb3 | apb3_d1_raw |
                            i_busy.ahb3_d1 | i_busy.flash);
    en_d.apb3_d1 = d1_ok & apb3_d1_raw;
    // apb1 and apb2 sit behind ahb1
    en_d.ahb1_d2 = d2_ok & (~i_c2.sleep | alloc_hit.ahb1 | i_busy.ahb1_d2 |
                            apb1_d2_raw | apb2_d2_raw);
    en_d.ahb2_d2 = d2_ok & (~i_c2.sleep | alloc_hit.ahb2 | i_busy.ahb2_d2);
    en_d.apb1_d2 = d2_ok & apb1_d2_raw;
    en_d.apb2_d2 = d2_ok & apb2_d2_raw;
    // d3 only stops with the system
    en_d.ahb4_d3 = ~i_sys_stop;
    en_d.apb4_d3 = ~i_sys_stop;
  end

  always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      en_q <= '0;
    end else begin
      en_q <= en_d;
    end
  end

  assign o_bridge_en = en_q;

endmodule

//--- verilog/rcc_bridge_stb.sv
`timescale 1ns/1ps

module rcc_bridge_stb import rcc_pkg::*; (
  input  logic        i_sys_clk,
  input  logic        i_rst_n,
  input  t_bus_tick   i_tick,
  input  t_bridge_vec i_bridge_en,
  output t_bridge_vec o_bridge_stb
);

  t_bridge_vec tick_map;

  // bus tick seen by each bridge
  assign tick_map.axi_d1  = i_tick.hclk;
  assign tick_map.ahb3_d1 = i_tick.hclk;
  assign tick_map.apb3_d1 = i_tick.pclk3_d1;
  assign tick_map.ahb1_d2 = i_tick.hclk;
  assign tick_map.ahb2_d2 = i_tick.hclk;
  assign tick_map.apb1_d2 = i_tick.pclk1_d2;
  assign tick_map.apb2_d2 = i_tick.pclk2_d2;
  assign tick_map.ahb4_d3 = i_tick.hclk;
  assign tick_map.apb4_d3 = i_tick.pclk4_d3;

  // one-cycle strobe per enabled bridge
  always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_bridge_stb <= '0;
    end else begin
      o_bridge_stb <= tick_map & i_bridge_en;
    end
  end

endmodule

//--- verilog/rcc_bus_clk_en.sv
`timescale 1ns/1ps

module rcc_bus_clk_en import rcc_pkg::*; (
  input  logic          i_sys_clk,
  input  logic          i_rst_n,
  input  t_prescale_cfg i_cfg,
  input  t_core_state   i_c1,
  input  t_core_state   i_c2,
  input  t_bus_alloc    i_c1_alloc,
  input  t_bus_alloc    i_c2_alloc,
  input  t_bridge_busy  i_busy,
  input  logic          i_d1_run,
  input  logic          i_d2_run,
  input  logic          i_sys_stop,
  output t_bridge_vec   o_bridge_stb
);

  t_bus_tick   bus_tick;
  t_bridge_vec bridge_en;

  // tick branch
  rcc_bus_prescalers u_prescalers (
    .i_sys_clk (i_sys_clk),
    .i_rst_n   (i_rst_n),
    .i_cfg     (i_cfg),
    .o_tick    (bus_tick)
  );

  // enable branch
  rcc_gate_ctrl u_gate_ctrl (
    .i_sys_clk   (i_sys_clk),
    .i_rst_n     (i_rst_n),
    .i_c1        (i_c1),
    .i_c2        (i_c2),
    .i_c1_alloc  (i_c1_alloc),
    .i_c2_alloc  (i_c2_alloc),
    .i_busy      (i_busy),
    .i_d1_run    (i_d1_run),
    .i_d2_run    (i_d2_run),
    .i_sys_stop  (i_sys_stop),
    .o_bridge_en (bridge_en)
  );

  rcc_bridge_stb u_bridge_stb (
    .i_sys_clk    (i_sys_clk),
    .i_rst_n      (i_rst_n),
    .i_tick       (bus_tick),
    .i_bridge_en  (bridge_en),
    .o_bridge_stb (o_bridge_stb)
  );

endmodule

//--- verification/rcc_bus_clk_en_asserts.sv
`timescale 1ns/1ps

module rcc_bus_clk_en_asserts import rcc_pkg::*; (
  input logic        i_sys_clk,
  input logic        i_rst_n,
  input logic        i_sys_stop,
  input t_bus_tick   i_tick,
  input t_bridge_vec i_bridge_stb
);

  logic apb_stb;
  logic d12_stb;

  // count of failed assertions
  int   fail_cnt = 0;

  assign apb_stb = i_bridge_stb.apb3_d1 | i_bridge_stb.apb1_d2 |
                   i_bridge_stb.apb2_d2 | i_bridge_stb.apb4_d3;

  // axi_d1 down to apb2_d2
  assign d12_stb = |i_bridge_stb[8:2];

  a_no_stb_in_reset: assert property (@(posedge i_sys_clk)
    !i_rst_n |-> (i_bridge_stb == '0))
    else begin
      $error("bridge strobe while reset is asserted");
      fail_cnt++;
    end

  // hclk tick advances the apb counter two register stages earlier
  a_apb_after_hclk: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
    apb_stb |-> $past(i_tick.hclk, 2))
    else begin
      $error("apb strobe without an earlier hclk tick");
      fail_cnt++;
    end

  a_stop_blocks_d12: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
    $past(i_sys_stop, 2) |-> !d12_stb)
    else begin
      $error("d1 or d2 strobe after system stop");
      fail_cnt++;
    end

endmodule

bind rcc_bus_clk_en rcc_bus_clk_en_asserts u_asserts (
  .i_sys_clk    (i_sys_clk),
  .i_rst_n      (i_rst_n),
  .i_sys_stop   (i_sys_stop),
  .i_tick       (bus_tick),
  .i_bridge_stb (o_bridge_stb)
);

//--- verification/rcc_bus_clk_en_tb.sv
`timescale 1ns/1ps

module rcc_bus_clk_en_tb import rcc_pkg::*; ();

  localparam int CLK_PERIOD    = 100;
  localparam int DRIVE_DELAY   = 10;
  localparam int RST_CYCLES    = 10;
  localparam int N_HPRE_ROUNDS = 7;
  localparam int N_APB_ROUNDS  = 4;
  localparam int N_EN_ROUNDS   = 60;
  localparam int N_STOP_ROUNDS = 40;
  // two strobes at the slowest divisor of each test plus settling
  localparam int HPRE_LIMIT    = 2 * 512 + 8;
  localparam int APB_LIMIT     = 2 * 16 * 16 + 8;
  // about four times the worst-case length of all tests
  localparam int MAX_CYCLES    = 40000;

  // bit positions inside t_bridge_vec
  localparam int B_APB3_D1 = 6;
  localparam int B_APB1_D2 = 3;
  localparam int B_APB2_D2 = 2;
  localparam int B_AHB4_D3 = 1;
  localparam int B_APB4_D3 = 0;

  logic          sys_clk;
  logic          rst_n;
  t_prescale_cfg cfg;
  t_core_state   c1;
  t_core_state   c2;
  t_bus_alloc    c1_alloc;
  t_bus_alloc    c2_alloc;
  t_bridge_busy  busy;
  logic          d1_run;
  logic          d2_run;
  logic          sys_stop;
  t_bridge_vec   bridge_stb;

  logic [31:0] lfsr_q;
  int          cycle_cnt;
  int          errors;
  int          err_base;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          gap_q [9];

  rcc_bus_clk_en uut (
    .i_sys_clk    (sys_clk),
    .i_rst_n      (rst_n),
    .i_cfg        (cfg),
    .i_c1         (c1),
    .i_c2         (c2),
    .i_c1_alloc   (c1_alloc),
    .i_c2_alloc   (c2_alloc),
    .i_busy       (busy),
    .i_d1_run     (d1_run),
    .i_d2_run     (d2_run),
    .i_sys_stop   (sys_stop),
    .o_bridge_stb (bridge_stb)
  );

  initial begin
    sys_clk = 1'b0;
    forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
  end

  // watchdog
  always @(posedge sys_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > MAX_CYCLES) begin
      $display("timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers and reference model
  ////////////////////////////////////////////////////////////////////////////

  // fibonacci lfsr with taps 32 22 2 1
  // one step per bit drawn
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic int hpre_div(input t_hpre_code code);
    case (code)
      4'd8:    return 2;
      4'd9:    return 4;
      4'd10:   return 8;
      4'd11:   return 16;
      4'd12:   return 64;
      4'd13:   return 128;
      4'd14:   return 256;
      4'd15:   return 512;
      default: return 1;
    endcase
  endfunction

  function automatic int ppre_div(input t_ppre_code code);
    case (code)
      3'd4:    return 2;
      3'd5:    return 4;
      3'd6:    return 8;
      3'd7:    return 16;
      default: return 1;
    endcase
  endfunction

  // bridge enables from the current inputs
  function automatic t_bridge_vec expected_enables();
    logic        c1_sm;
    logic        c2_sm;
    logic        d1q;
    logic        d2q;
    logic        apb1;
    logic        apb2;
    logic        apb3;
    t_bridge_vec e;
    c1_sm = c1.sleep && !c1.deepsleep;
    c2_sm = c2.sleep && !c2.deepsleep;
    d1q   = d1_run && !sys_stop;
    d2q   = d2_run && !sys_stop;
    apb1  = !c2.sleep || (c1_sm && c1_alloc.apb1) || (c2_sm && c2_alloc.apb1) || busy.apb1_d2;
    apb2  = !c2.sleep || (c1_sm && c1_alloc.apb2) || (c2_sm && c2_alloc.apb2) || busy.apb2_d2;
    apb3  = !c1.sleep || (c1_sm && c1_alloc.apb3) || (c2_sm && c2_alloc.apb3) || busy.apb3_d1;
    e.axi_d1  = d1q && (!c1.sleep || busy.axi_d1);
    e.ahb3_d1 = d1q && (!c1.sleep || (c1_sm && c1_alloc.ahb3) || (c2_sm && c2_alloc.ahb3) ||
                        busy.ahb3_d1 || apb3 || busy.flash);
    e.apb3_d1 = d1q && apb3;
    e.ahb1_d2 = d2q && (!c2.sleep || (c1_sm && c1_alloc.ahb1) || (c2_sm && c2_alloc.ahb1) ||
                        busy.ahb1_d2 || apb1 || apb2);
    e.ahb2_d2 = d2q && (!c2.sleep || (c1_sm && c1_alloc.ahb2) || (c2_sm && c2_alloc.ahb2) ||
                        busy.ahb2_d2);
    e.apb1_d2 = d2q && apb1;
    e.apb2_d2 = d2q && apb2;
    e.ahb4_d3 = !sys_stop;
    e.apb4_d3 = !sys_stop;
    return e;
  endfunction

  task automatic next_cycle();
    @(posedge sys_clk);
    #(DRIVE_DELAY);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic set_defaults();
    cfg      = '0;
    c1       = '0;
    c2       = '0;
    c1_alloc = '0;
    c2_alloc = '0;
    busy     = '0;
    d1_run   = 1'b1;
    d2_run   = 1'b1;
    sys_stop = 1'b0;
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors != err_base) begin
      tests_failed++;
      $display("test %0d %s: FAILED with %0d errors", tests_run, name, errors - err_base);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
    err_base = errors;
  endtask

  // gap between the first two strobes of each masked bridge
  task automatic measure_gaps(input logic [8:0] mask, input int limit);
    int         seen [9];
    int         last [9];
    int         n;
    logic [8:0] stb;
    logic [8:0] done;
    for (int b = 0; b < 9; b++) begin
      seen[b]  = 0;
      last[b]  = 0;
      gap_q[b] = -1;
    end
    done = ~mask;
    n    = 0;
    while (done != '1 && n < limit) begin
      next_cycle();
      n++;
      stb = bridge_stb;
      for (int b = 0; b < 9; b++) begin
        if (!done[b] && stb[b]) begin
          seen[b]++;
          if (seen[b] == 2) begin
            gap_q[b] = n - last[b];
            done[b]  = 1'b1;
          end
          last[b] = n;
        end
      end
    end
    if (done != '1) begin
      $display("at %0t: bridges %b gave fewer than two strobes in %0d cycles",
               $time, ~done, limit);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    t_hpre_code  code;
    int          hd;
    lfsr_q       = 32'hc61e3581;
    cycle_cnt    = 0;
    errors       = 0;
    err_base     = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst_n        = 1'b0;
    set_defaults();
    repeat (RST_CYCLES) @(posedge sys_clk);
    #(DRIVE_DELAY);
    rst_n = 1'b1;

    // everything on at divide by 1
    repeat (6) next_cycle();
    repeat (32) begin
      next_cycle();
      check_value("o_bridge_stb", 32'(bridge_stb), 32'h1ff);
    end
    report_test("reset and divide by 1");

    // first round uses code 12 to cover the skipped divide by 32
    for (int i = 0; i < N_HPRE_ROUNDS; i++) begin
      if (i == 0) begin
        code = 4'd12;
      end else begin
        r    = rand_bits(4);
        code = r[3:0];
      end
      cfg.hpre = code;
      repeat (4) next_cycle();
      measure_gaps(9'(1) << B_AHB4_D3, HPRE_LIMIT);
      check_value($sformatf("ahb4_d3 gap at hpre %0d", code), gap_q[B_AHB4_D3],
                  hpre_div(code));
    end
    report_test("hpre divide");

    for (int i = 0; i < N_APB_ROUNDS; i++) begin
      r           = rand_bits(3);
      cfg.hpre    = {r[2], 1'b0, r[1:0]};
      r           = rand_bits(12);
      cfg.d1ppre  = r[2:0];
      cfg.d2ppre1 = r[5:3];
      cfg.d2ppre2 = r[8:6];
      cfg.d3ppre  = r[11:9];
      hd          = hpre_div(cfg.hpre);
      repeat (4) next_cycle();
      measure_gaps((9'(1) << B_APB3_D1) | (9'(1) << B_APB1_D2) | (9'(1) << B_APB2_D2) |
                   (9'(1) << B_APB4_D3), APB_LIMIT);
      check_value("apb3_d1 gap", gap_q[B_APB3_D1], hd * ppre_div(cfg.d1ppre));
      check_value("apb1_d2 gap", gap_q[B_APB1_D2], hd * ppre_div(cfg.d2ppre1));
      check_value("apb2_d2 gap", gap_q[B_APB2_D2], hd * ppre_div(cfg.d2ppre2));
      check_value("apb4_d3 gap", gap_q[B_APB4_D3], hd * ppre_div(cfg.d3ppre));
    end
    report_test("apb divide");

    cfg = '0;
    repeat (6) next_cycle();
    repeat (N_EN_ROUNDS) begin
      r        = rand_bits(24);
      c1       = r[1:0];
      c2       = r[3:2];
      c1_alloc = r[9:4];
      c2_alloc = r[15:10];
      busy     = r[23:16];
      next_cycle();
      next_cycle();
      check_value("o_bridge_stb", 32'(bridge_stb), 32'(expected_enables()));
    end
    report_test("sleep and busy enables");

    set_defaults();
    repeat (2) next_cycle();
    repeat (N_STOP_ROUNDS) begin
      r        = rand_bits(3);
      sys_stop = r[0];
      d1_run   = r[1];
      d2_run   = r[2];
      next_cycle();
      next_cycle();
      check_value("o_bridge_stb", 32'(bridge_stb), 32'(expected_enables()));
    end
    report_test("stop and domain run");

    // failures of the bound assertions
    errors += uut.u_asserts.fail_cnt;

    $display("tests %0d, failed %0d, checks %0d, errors %0d, cycles %0d",
             tests_run, tests_failed, checks, errors, cycle_cnt);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+verilog
verilog/rcc_pkg.sv
verilog/rcc_prescaler.sv
verilog/rcc_bus_prescalers.sv
verilog/rcc_gate_ctrl.sv
verilog/rcc_bridge_stb.sv
verilog/rcc_bus_clk_en.sv
verification/rcc_bus_clk_en_asserts.sv
verification/rcc_bus_clk_en_tb.sv

//--- Bender.yml
package:
  name: rcc_bus_clk_en

sources:
  # rtl
  - include_dirs:
      - verilog
    files:
      - verilog/rcc_pkg.sv
      - verilog/rcc_prescaler.sv
      - verilog/rcc_bus_prescalers.sv
      - verilog/rcc_gate_ctrl.sv
      - verilog/rcc_bridge_stb.sv
      - verilog/rcc_bus_clk_en.sv

  # verification
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/rcc_bus_clk_en_asserts.sv
      - verification/rcc_bus_clk_en_tb.sv
